/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module tb_sdram_ctrl -f sim.f -o Vtb
	out=$$(./obj_dir/Vtb 2>&1); echo "$$out"; echo "$$out" | grep -q "^Test passed$$"

clean:
	rm -rf obj_dir

/* include/sdram_macros.svh */
// SDRAM timing and geometry
`ifndef SDRAM_MACROS_SVH
`define SDRAM_MACROS_SVH

// Clock
`define SDRAM_MHZ            50
`define SDRAM_CYCLE_NS       (1000 / `SDRAM_MHZ)

// Geometry in words
`define SDRAM_ADDR_W         25
`define SDRAM_COL_W          9
`define SDRAM_BANK_W         2
`define SDRAM_ROW_W          (`SDRAM_ADDR_W - `SDRAM_COL_W - `SDRAM_BANK_W)

// CAS latency in cycles
`define SDRAM_READ_LATENCY   2

// Device waits rounded up to whole cycles
`define SDRAM_TRCD_CYCLES    ((20 + `SDRAM_CYCLE_NS - 1) / `SDRAM_CYCLE_NS)
`define SDRAM_TRP_CYCLES     ((20 + `SDRAM_CYCLE_NS - 1) / `SDRAM_CYCLE_NS)
`define SDRAM_TRFC_CYCLES    ((60 + `SDRAM_CYCLE_NS - 1) / `SDRAM_CYCLE_NS)

// 100us power-up wait
`define SDRAM_START_DELAY    (100000 / `SDRAM_CYCLE_NS)
// 64ms spread over every row
`define SDRAM_REFRESH_CYCLES ((64000 * `SDRAM_MHZ) / (2 ** `SDRAM_ROW_W) - 1)

// Burst length 1, sequential, CAS 2
`define SDRAM_MODE_REG       {4'b0000, 1'b0, 2'b00, 3'b010, 1'b0, 3'b000}
// Auto-precharge on column commands, all banks on PRECHARGE
`define SDRAM_AP_BIT         10

`endif

/* rtl/sdram_bank_tracker.sv */
// SDRAM open row tracker
`timescale 1ns/1ns
`include "sdram_macros.svh"

module sdram_bank_tracker
(
     input  logic                       clk_i
    ,input  logic                       rst_i
    ,input  sdram_cmd_pkg::sdram_bank_t bank_i
    ,input  sdram_ctrl_pkg::row_t       row_i
    ,input  logic                       activate_i
    ,input  logic                       precharge_i
    ,input  logic                       precharge_all_i
    ,output logic                       row_hit_o
    ,output logic                       bank_open_o
    ,output logic                       any_open_o
);
    import sdram_cmd_pkg::*;
    import sdram_ctrl_pkg::*;

    localparam int BANKS = 1 << `SDRAM_BANK_W;

    logic [BANKS-1:0] open_q;
    row_t             row_q [BANKS];

    // Open flag per bank
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            open_q <= '0;
        else if (precharge_all_i)
            open_q <= '0;
        else if (precharge_i)
            open_q[bank_i] <= 1'b0;
        else if (activate_i)
            open_q[bank_i] <= 1'b1;
    end

    // Active row per bank
    always_ff @(posedge clk_i)
    begin
        if (activate_i)
            row_q[bank_i] <= row_i;
    end

    //--------------------------------------------------
    // Lookup for the addressed bank
    //--------------------------------------------------
    assign bank_open_o = open_q[bank_i];
    assign row_hit_o   = open_q[bank_i] && (row_q[bank_i] == row_i);
    assign any_open_o  = |open_q;

endmodule

/* rtl/sdram_cmd_out.sv */
// SDRAM command and pin registers
`timescale 1ns/1ns
`include "sdram_macros.svh"

module sdram_cmd_out
(
     input  logic                        clk_i
    ,input  logic                        rst_i
    ,input  sdram_ctrl_pkg::ctrl_state_t state_i
    ,input  sdram_cmd_pkg::sdram_bank_t  bank_i
    ,input  sdram_ctrl_pkg::row_t        row_i
    ,input  sdram_ctrl_pkg::col_t        col_i
    ,input  logic                        precharge_all_i
    ,input  sdram_cmd_pkg::sdram_data_t  write_data_i
    ,input  sdram_cmd_pkg::sdram_dqm_t   wr_i
    ,input  logic                        cke_on_i
    ,input  logic                        init_precharge_i
    ,input  logic                        init_refresh_i
    ,input  logic                        init_load_mode_i
    ,output logic                        cke_o
    ,output logic                        cs_o
    ,output logic                        ras_o
    ,output logic                        cas_o
    ,output logic                        we_o
    ,output sdram_cmd_pkg::sdram_addr_t  addr_o
    ,output sdram_cmd_pkg::sdram_bank_t  ba_o
    ,output sdram_cmd_pkg::sdram_dqm_t   dqm_o
    ,output sdram_cmd_pkg::sdram_data_t  data_o
    ,output logic                        data_oe_o
);
    import sdram_cmd_pkg::*;
    import sdram_ctrl_pkg::*;

    // A10 alone, selects all banks on PRECHARGE
    localparam sdram_addr_t ALL_BANKS_ADDR = sdram_addr_t'(1) << `SDRAM_AP_BIT;

    sdram_cmd_t  cmd_q;
    sdram_addr_t col_addr;

    // Column address with auto-precharge off
    always_comb
    begin
        col_addr                = sdram_addr_t'(col_i);
        col_addr[`SDRAM_AP_BIT] = 1'b0;
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            cmd_q     <= CMD_NOP;
            cke_o     <= 1'b0;
            addr_o    <= '0;
            ba_o      <= '0;
            dqm_o     <= '0;
            data_oe_o <= 1'b0;
        end
        else
        begin
            // NOP unless the state says otherwise
            cmd_q     <= CMD_NOP;
            addr_o    <= '0;
            ba_o      <= '0;
            data_oe_o <= 1'b0;
            case (state_i)
                ST_INIT:
                begin
                    if (cke_on_i)
                        cke_o <= 1'b1;
                    if (init_precharge_i)
                    begin
                        cmd_q  <= CMD_PRECHARGE;
                        addr_o <= ALL_BANKS_ADDR;
                    end
                    if (init_refresh_i)
                        cmd_q <= CMD_REFRESH;
                    if (init_load_mode_i)
                    begin
                        cmd_q  <= CMD_LOAD_MODE;
                        addr_o <= `SDRAM_MODE_REG;
                    end
                end
                ST_ACTIVATE:
                begin
                    cmd_q  <= CMD_ACTIVE;
                    addr_o <= row_i;
                    ba_o   <= bank_i;
                end
                ST_PRECHARGE:
                begin
                    // Single bank on a row miss, all banks before refresh
                    cmd_q  <= CMD_PRECHARGE;
                    addr_o <= precharge_all_i ? ALL_BANKS_ADDR : '0;
                    ba_o   <= bank_i;
                end
                ST_REFRESH:
                    cmd_q <= CMD_REFRESH;
                ST_READ:
                begin
                    cmd_q  <= CMD_READ;
                    addr_o <= col_addr;
                    ba_o   <= bank_i;
                    dqm_o  <= '0;
                end
                ST_WRITE:
                begin
                    cmd_q     <= CMD_WRITE;
                    addr_o    <= col_addr;
                    ba_o      <= bank_i;
                    // Mask is active low per byte
                    dqm_o     <= ~wr_i;
                    data_oe_o <= 1'b1;
                end
                default:
                    cmd_q <= CMD_NOP;
            endcase
        end
    end

    // Write data register
    always_ff @(posedge clk_i)
    begin
        if (state_i == ST_WRITE)
            data_o <= write_data_i;
    end

    assign cs_o  = cmd_q[3];
    assign ras_o = cmd_q[2];
    assign cas_o = cmd_q[1];
    assign we_o  = cmd_q[0];

endmodule

/* rtl/sdram_cmd_pkg.sv */
// SDRAM device command and pin types
`include "sdram_macros.svh"

package sdram_cmd_pkg;

    // Encoded as {cs, ras, cas, we}
    typedef enum logic [3:0]
    {
        CMD_NOP       = 4'b0111,
        CMD_ACTIVE    = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_WRITE     = 4'b0100,
        CMD_PRECHARGE = 4'b0010,
        CMD_REFRESH   = 4'b0001,
        CMD_LOAD_MODE = 4'b0000
    } sdram_cmd_t;

    typedef logic [`SDRAM_ROW_W-1:0]  sdram_addr_t;
    typedef logic [`SDRAM_BANK_W-1:0] sdram_bank_t;
    typedef logic [31:0]              sdram_data_t;
    typedef logic [3:0]               sdram_dqm_t;

endpackage

/* rtl/sdram_ctrl_pkg.sv */
// SDRAM controller internal types
`include "sdram_macros.svh"

package sdram_ctrl_pkg;

    // Main FSM states
    typedef enum logic [3:0]
    {
        ST_INIT,
        ST_DELAY,
        ST_IDLE,
        ST_ACTIVATE,
        ST_READ,
        ST_READ_WAIT,
        ST_WRITE,
        ST_PRECHARGE,
        ST_REFRESH
    } ctrl_state_t;

    // Host byte address and its fields
    typedef logic [31:0]              host_addr_t;
    typedef logic [`SDRAM_ROW_W-1:0]  row_t;
    typedef logic [`SDRAM_COL_W-1:0]  col_t;

    // Counters
    typedef logic [3:0]               delay_t;
    typedef logic [16:0]              refresh_cnt_t;

endpackage

/* rtl/sdram_ctrl_top.sv */
// SDRAM controller top level
`timescale 1ns/1ns

module sdram_ctrl_top
(
     input  logic                       clk_i
    ,input  logic                       rst_i
    // Host side
    ,input  sdram_cmd_pkg::sdram_dqm_t  wr_i
    ,input  logic                       rd_i
    ,input  sdram_ctrl_pkg::host_addr_t addr_i
    ,input  sdram_cmd_pkg::sdram_data_t write_data_i
    ,output logic                       accept_o
    ,output logic                       ack_o
    ,output sdram_cmd_pkg::sdram_data_t read_data_o
    // Device side
    ,input  sdram_cmd_pkg::sdram_data_t data_i
    ,output logic                       cke_o
    ,output logic                       cs_o
    ,output logic                       ras_o
    ,output logic                       cas_o
    ,output logic                       we_o
    ,output sdram_cmd_pkg::sdram_addr_t addr_o
    ,output sdram_cmd_pkg::sdram_bank_t ba_o
    ,output sdram_cmd_pkg::sdram_dqm_t  dqm_o
    ,output sdram_cmd_pkg::sdram_data_t data_o
    ,output logic                       data_oe_o
);
    import sdram_cmd_pkg::*;
    import sdram_ctrl_pkg::*;

    ctrl_state_t state;
    sdram_bank_t bank;
    row_t        row;
    col_t        col;
    logic        activate, precharge, precharge_all;
    logic        row_hit, bank_open, any_open;
    logic        refresh_req, refresh_done;
    logic        cke_on, init_precharge, init_refresh, init_load_mode;

    //--------------------------------------------------
    // Control path
    //--------------------------------------------------
    sdram_refresh_timer u_timer
    (
         .clk_i(clk_i), .rst_i(rst_i), .refresh_done_i(refresh_done)
        ,.refresh_req_o(refresh_req), .cke_on_o(cke_on)
        ,.init_precharge_o(init_precharge), .init_refresh_o(init_refresh)
        ,.init_load_mode_o(init_load_mode)
    );

    sdram_bank_tracker u_tracker
    (
         .clk_i(clk_i), .rst_i(rst_i), .bank_i(bank), .row_i(row)
        ,.activate_i(activate), .precharge_i(precharge), .precharge_all_i(precharge_all)
        ,.row_hit_o(row_hit), .bank_open_o(bank_open), .any_open_o(any_open)
    );

    sdram_sequencer u_seq
    (
         .clk_i(clk_i), .rst_i(rst_i), .wr_i(wr_i), .rd_i(rd_i), .addr_i(addr_i)
        ,.refresh_req_i(refresh_req), .row_hit_i(row_hit), .bank_open_i(bank_open)
        ,.any_open_i(any_open), .state_o(state), .bank_o(bank), .row_o(row), .col_o(col)
        ,.activate_o(activate), .precharge_o(precharge), .precharge_all_o(precharge_all)
        ,.refresh_done_o(refresh_done), .accept_o(accept_o)
    );

    // Pin and response registers
    sdram_cmd_out u_cmd
    (
         .clk_i(clk_i), .rst_i(rst_i), .state_i(state), .bank_i(bank), .row_i(row)
        ,.col_i(col), .precharge_all_i(precharge_all), .write_data_i(write_data_i)
        ,.wr_i(wr_i), .cke_on_i(cke_on), .init_precharge_i(init_precharge)
        ,.init_refresh_i(init_refresh), .init_load_mode_i(init_load_mode)
        ,.cke_o(cke_o), .cs_o(cs_o), .ras_o(ras_o), .cas_o(cas_o), .we_o(we_o)
        ,.addr_o(addr_o), .ba_o(ba_o), .dqm_o(dqm_o), .data_o(data_o)
        ,.data_oe_o(data_oe_o)
    );

    sdram_response u_resp
    (
         .clk_i(clk_i), .rst_i(rst_i), .state_i(state), .data_i(data_i)
        ,.read_data_o(read_data_o), .ack_o(ack_o)
    );

endmodule

/* rtl/sdram_refresh_timer.sv */
// SDRAM init and refresh timer
`timescale 1ns/1ns
`include "sdram_macros.svh"

module sdram_refresh_timer
(
     input  logic clk_i
    ,input  logic rst_i
    ,input  logic refresh_done_i
    ,output logic refresh_req_o
    ,output logic cke_on_o
    ,output logic init_precharge_o
    ,output logic init_refresh_o
    ,output logic init_load_mode_o
);
    import sdram_ctrl_pkg::*;

    localparam refresh_cnt_t START_LOAD   = refresh_cnt_t'(`SDRAM_START_DELAY + 100);
    localparam refresh_cnt_t REFRESH_LOAD = refresh_cnt_t'(`SDRAM_REFRESH_CYCLES);

    refresh_cnt_t cnt_q;
    logic         init_done_q;

    // Down counter, first expiry ends power-up
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            cnt_q         <= START_LOAD;
            refresh_req_o <= 1'b0;
            init_done_q   <= 1'b0;
        end
        else if (cnt_q == '0)
        begin
            cnt_q         <= REFRESH_LOAD;
            refresh_req_o <= 1'b1;
            init_done_q   <= 1'b1;
        end
        else
        begin
            cnt_q <= cnt_q - 1'b1;
            // Held until the FSM issues REFRESH
            if (refresh_done_i)
                refresh_req_o <= 1'b0;
        end
    end

    // Init schedule near the end of the wait
    assign cke_on_o         = !init_done_q && (cnt_q == refresh_cnt_t'(50));
    assign init_precharge_o = !init_done_q && (cnt_q == refresh_cnt_t'(40));
    assign init_refresh_o   = !init_done_q && (cnt_q == refresh_cnt_t'(30) ||
                                               cnt_q == refresh_cnt_t'(20));
    assign init_load_mode_o = !init_done_q && (cnt_q == refresh_cnt_t'(10));

endmodule

/* rtl/sdram_response.sv */
// SDRAM read capture and host ack
`timescale 1ns/1ns
`include "sdram_macros.svh"

module sdram_response
(
     input  logic                        clk_i
    ,input  logic                        rst_i
    ,input  sdram_ctrl_pkg::ctrl_state_t state_i
    ,input  sdram_cmd_pkg::sdram_data_t  data_i
    ,output sdram_cmd_pkg::sdram_data_t  read_data_o
    ,output logic                        ack_o
);
    import sdram_cmd_pkg::*;
    import sdram_ctrl_pkg::*;

    localparam int RL = `SDRAM_READ_LATENCY;

    // One bit per READ issued, oldest at the top
    logic [RL+1:0] rd_q;
    sdram_data_t   sample_q;

    // Input capture flop
    always_ff @(posedge clk_i)
        sample_q <= data_i;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            rd_q  <= '0;
            ack_o <= 1'b0;
        end
        else
        begin
            rd_q  <= {rd_q[RL:0], (state_i == ST_READ)};
            // Write acks right away, read once its word is captured
            ack_o <= (state_i == ST_WRITE) || rd_q[RL+1];
        end
    end

    // Hold the word for the ack cycle
    always_ff @(posedge clk_i)
    begin
        if (rd_q[RL+1])
            read_data_o <= sample_q;
    end

endmodule

/* rtl/sdram_sequencer.sv */
// SDRAM main state machine
`timescale 1ns/1ns
`include "sdram_macros.svh"

module sdram_sequencer
(
     input  logic                        clk_i
    ,input  logic                        rst_i
    ,input  logic [3:0]                  wr_i
    ,input  logic                        rd_i
    ,input  sdram_ctrl_pkg::host_addr_t  addr_i
    ,input  logic                        refresh_req_i
    ,input  logic                        row_hit_i
    ,input  logic                        bank_open_i
    ,input  logic                        any_open_i
    ,output sdram_ctrl_pkg::ctrl_state_t state_o
    ,output sdram_cmd_pkg::sdram_bank_t  bank_o
    ,output sdram_ctrl_pkg::row_t        row_o
    ,output sdram_ctrl_pkg::col_t        col_o
    ,output logic                        activate_o
    ,output logic                        precharge_o
    ,output logic                        precharge_all_o
    ,output logic                        refresh_done_o
    ,output logic                        accept_o
);
    import sdram_ctrl_pkg::*;

    // Byte address split with the low two bits ignored
    localparam int COL_LSB  = 2;
    localparam int BANK_LSB = COL_LSB + `SDRAM_COL_W;
    localparam int ROW_LSB  = BANK_LSB + `SDRAM_BANK_W;

    ctrl_state_t state_q, next_state;
    ctrl_state_t target_q, target_state;
    ctrl_state_t delay_state_q;
    delay_t      delay_q, delay_next;
    logic        host_req;
    logic        chain_read;
    ctrl_state_t access_state;

    assign col_o  = addr_i[COL_LSB +: `SDRAM_COL_W];
    assign bank_o = addr_i[BANK_LSB +: `SDRAM_BANK_W];
    assign row_o  = addr_i[ROW_LSB +: `SDRAM_ROW_W];

    assign host_req     = (wr_i != 4'b0000) || rd_i;
    assign access_state = rd_i ? ST_READ : ST_WRITE;
    // Another read hit right behind with no refresh due
    assign chain_read   = !refresh_req_i && rd_i && row_hit_i;

    //--------------------------------------------------
    // Next state
    //--------------------------------------------------
    always_comb
    begin
        next_state   = state_q;
        target_state = target_q;
        case (state_q)
            ST_INIT:
            begin
                // First timer expiry marks init complete
                if (refresh_req_i)
                    next_state = ST_IDLE;
            end
            ST_IDLE:
            begin
                // Refresh wins over host access
                if (refresh_req_i)
                begin
                    next_state   = any_open_i ? ST_PRECHARGE : ST_REFRESH;
                    target_state = ST_REFRESH;
                end
                else if (host_req)
                begin
                    target_state = access_state;
                    if (row_hit_i)
                        next_state = access_state;
                    else if (bank_open_i)
                        next_state = ST_PRECHARGE;
                    else
                        next_state = ST_ACTIVATE;
                end
            end
            ST_ACTIVATE:  next_state = target_q;
            ST_READ:      next_state = ST_READ_WAIT;
            ST_READ_WAIT: next_state = chain_read ? ST_READ : ST_IDLE;
            ST_PRECHARGE: next_state = (target_q == ST_REFRESH) ? ST_REFRESH : ST_ACTIVATE;
            ST_DELAY:     next_state = delay_state_q;
            default:      next_state = ST_IDLE;
        endcase
    end

    // Wait inserted after the current state
    always_comb
    begin
        case (state_q)
            ST_ACTIVATE:  delay_next = delay_t'(`SDRAM_TRCD_CYCLES);
            // CAS wait skipped when chaining reads
            ST_READ_WAIT: delay_next = chain_read ? '0 : delay_t'(`SDRAM_READ_LATENCY);
            ST_PRECHARGE: delay_next = delay_t'(`SDRAM_TRP_CYCLES);
            ST_REFRESH:   delay_next = delay_t'(`SDRAM_TRFC_CYCLES);
            ST_DELAY:     delay_next = delay_q - 1'b1;
            default:      delay_next = '0;
        endcase
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            state_q       <= ST_INIT;
            target_q      <= ST_IDLE;
            delay_state_q <= ST_IDLE;
            delay_q       <= '0;
        end
        else
        begin
            state_q  <= (delay_next != '0) ? ST_DELAY : next_state;
            target_q <= target_state;
            delay_q  <= delay_next;
            // Remember where to resume after the wait
            if (delay_next != '0)
                delay_state_q <= next_state;
        end
    end

    //--------------------------------------------------
    // Strobes to the other blocks
    //--------------------------------------------------
    assign state_o         = state_q;
    assign activate_o      = (state_q == ST_ACTIVATE);
    assign precharge_o     = (state_q == ST_PRECHARGE) && (target_q != ST_REFRESH);
    assign precharge_all_o = (state_q == ST_PRECHARGE) && (target_q == ST_REFRESH);
    assign refresh_done_o  = (state_q == ST_REFRESH);
    assign accept_o        = (state_q == ST_READ) || (state_q == ST_WRITE);

endmodule

/* sim.f */
+incdir+include
rtl/sdram_cmd_pkg.sv
rtl/sdram_ctrl_pkg.sv
rtl/sdram_refresh_timer.sv
rtl/sdram_bank_tracker.sv
rtl/sdram_sequencer.sv
rtl/sdram_cmd_out.sv
rtl/sdram_response.sv
rtl/sdram_ctrl_top.sv
verification/sdram_model.sv
verification/tb_sdram_ctrl.sv

/* verification/sdram_model.sv */
// Behavioral SDRAM device model
`timescale 1ns/1ns
`include "sdram_macros.svh"

module sdram_model
(
     input  logic        clk_i
    ,input  logic        cs_i
    ,input  logic        ras_i
    ,input  logic        cas_i
    ,input  logic        we_i
    ,input  logic [13:0] addr_i
    ,input  logic [1:0]  ba_i
    ,input  logic [3:0]  dqm_i
    ,input  logic [31:0] data_i
    ,output logic [31:0] data_o
    ,output int          refresh_count_o
    ,output int          single_precharge_count_o
    ,output int          activate_count_o
    ,output logic [1:0]  last_precharge_bank_o
    ,output logic        violation_o
);
    // JEDEC truth table on {cs, ras, cas, we}
    localparam logic [3:0] ACT = 4'b0011, RD = 4'b0101, WR = 4'b0100;
    localparam logic [3:0] PRE = 4'b0010, REF = 4'b0001;

    logic [31:0] mem [logic [24:0]];
    logic [3:0]  open_q = '0;
    logic [13:0] row_q [4];
    logic [31:0] rd_word_q = '0;
    logic [24:0] key;
    logic [31:0] word;

    // Unwritten words read back a pattern of their address
    function automatic logic [31:0] fill(input logic [24:0] k);
        return {7'h00, k} ^ 32'hc3a5_0f96;
    endfunction

    initial
    begin
        data_o = '0;
        refresh_count_o = 0;
        single_precharge_count_o = 0;
        activate_count_o = 0;
        last_precharge_bank_o = '0;
        violation_o = 1'b0;
    end

    // Commands sampled on the rising edge
    always @(posedge clk_i)
    begin
        key = {row_q[ba_i], ba_i, addr_i[8:0]};
        // CAS 2, one stage between command edge and data
        data_o <= rd_word_q;
        case ({cs_i, ras_i, cas_i, we_i})
            ACT:
            begin
                if (open_q[ba_i])
                begin
                    $display("ACTIVATE to bank %0d which is already open", ba_i);
                    violation_o <= 1'b1;
                end
                open_q[ba_i] <= 1'b1;
                row_q[ba_i]  <= addr_i;
                activate_count_o <= activate_count_o + 1;
            end
            RD, WR:
            begin
                if (!open_q[ba_i])
                begin
                    $display("READ or WRITE to closed bank %0d", ba_i);
                    violation_o <= 1'b1;
                end
                word = mem.exists(key) ? mem[key] : fill(key);
                if (!we_i)
                begin
                    // Byte lanes with dqm low take new data
                    for (int b = 0; b < 4; b++)
                        if (!dqm_i[b])
                            word[8*b +: 8] = data_i[8*b +: 8];
                    mem[key] = word;
                end
                else
                    rd_word_q <= word;
            end
            PRE:
            begin
                if (addr_i[`SDRAM_AP_BIT])
                    open_q <= '0;
                else
                begin
                    open_q[ba_i] <= 1'b0;
                    single_precharge_count_o <= single_precharge_count_o + 1;
                    last_precharge_bank_o <= ba_i;
                end
            end
            REF:
            begin
                if (open_q != '0)
                begin
                    $display("REFRESH while a bank is open");
                    violation_o <= 1'b1;
                end
                refresh_count_o <= refresh_count_o + 1;
            end
            default: ;
        endcase
    end

endmodule

/* verification/tb_sdram_ctrl.sv */
// SDRAM controller testbench
`timescale 1ns/1ns
`include "sdram_macros.svh"

module tb_sdram_ctrl;

    localparam int TIMEOUT = 200;
    localparam logic [3:0] NOP = 4'b0111, PRE = 4'b0010, REF = 4'b0001, LMR = 4'b0000;
    localparam logic [3:0] RD = 4'b0101, WR = 4'b0100;

    logic        clk_i = 1'b0;
    logic        rst_i;
    logic [3:0]  wr_i;
    logic        rd_i;
    logic [31:0] addr_i, write_data_i, read_data_o, dev_rdata, data_o;
    logic        accept_o, ack_o, cke_o, cs_o, ras_o, cas_o, we_o, data_oe_o;
    logic [13:0] dev_addr;
    logic [1:0]  ba_o, last_pre_bank;
    logic [3:0]  dqm_o, last_dqm;
    int          cycle_q = 0;
    int          refresh_count, pre_count, act_count;
    logic        violation;

    sdram_ctrl_top sdram_ctrl_top_i
    (
         .clk_i(clk_i), .rst_i(rst_i), .wr_i(wr_i), .rd_i(rd_i), .addr_i(addr_i)
        ,.write_data_i(write_data_i), .accept_o(accept_o), .ack_o(ack_o)
        ,.read_data_o(read_data_o), .data_i(dev_rdata), .cke_o(cke_o), .cs_o(cs_o)
        ,.ras_o(ras_o), .cas_o(cas_o), .we_o(we_o), .addr_o(dev_addr), .ba_o(ba_o)
        ,.dqm_o(dqm_o), .data_o(data_o), .data_oe_o(data_oe_o)
    );

    sdram_model u_model
    (
         .clk_i(clk_i), .cs_i(cs_o), .ras_i(ras_o), .cas_i(cas_o), .we_i(we_o)
        ,.addr_i(dev_addr), .ba_i(ba_o), .dqm_i(dqm_o), .data_i(data_o), .data_o(dev_rdata)
        ,.refresh_count_o(refresh_count), .single_precharge_count_o(pre_count)
        ,.activate_count_o(act_count), .last_precharge_bank_o(last_pre_bank)
        ,.violation_o(violation)
    );

    // 100 ns clock
    always #50 clk_i = ~clk_i;

    always @(posedge clk_i)
        cycle_q <= cycle_q + 1;

    // Device protocol violation ends the run
    always @(posedge clk_i)
    begin
        if (violation)
        begin
            $display("Test failed");
            $fatal(1, "device protocol violation");
        end
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got)
        begin
            $display("error %s expected 0x%08h got 0x%08h", name, exp, got);
            $display("Test failed");
            $fatal(1, "mismatch");
        end
    endtask

    // Byte address from bank and row with a random column
    function automatic logic [31:0] rand_addr(input logic [1:0] bank, input logic [13:0] row);
        return {5'b0, row, bank, 9'($urandom), 2'b00};
    endfunction

    // One host access returning data and ack latency from accept
    task automatic access(input logic [3:0] wr, input logic [31:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output int lat);
        int n;
        int t0;
        wr_i = wr;
        rd_i = (wr == 4'b0000);
        addr_i = addr;
        write_data_i = wdata;
        n = 0;
        @(negedge clk_i);
        while (!accept_o)
        begin
            n++;
            if (n > TIMEOUT)
                fail_now("request was never accepted");
            @(negedge clk_i);
        end
        t0 = cycle_q;
        @(posedge clk_i);
        #1;
        wr_i = '0;
        rd_i = 1'b0;
        @(negedge clk_i);
        last_dqm = dqm_o;
        // Column command on the pins one cycle after accept
        check("command", (wr != 4'b0000) ? WR : RD, {cs_o, ras_o, cas_o, we_o});
        check("data_oe_o", {31'b0, wr != 4'b0000}, data_oe_o);
        n = 0;
        while (!ack_o)
        begin
            n++;
            if (n > TIMEOUT)
                fail_now("no ack after accept");
            @(negedge clk_i);
        end
        lat = cycle_q - t0;
        rdata = read_data_o;
        @(posedge clk_i);
        #1;
    endtask

    // Second read presented right behind the first
    task automatic read_pair(input logic [31:0] a, input logic [31:0] b,
                             output logic [31:0] d0, output logic [31:0] d1);
        int n;
        int got;
        logic b_acc;
        rd_i = 1'b1;
        addr_i = a;
        n = 0;
        @(negedge clk_i);
        while (!accept_o)
        begin
            n++;
            if (n > TIMEOUT)
                fail_now("first read was never accepted");
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
        addr_i = b;
        got = 0;
        b_acc = 1'b0;
        n = 0;
        while (got < 2)
        begin
            @(negedge clk_i);
            if (ack_o)
            begin
                if (got == 0)
                    d0 = read_data_o;
                else
                    d1 = read_data_o;
                got++;
            end
            n++;
            if (n > TIMEOUT)
                fail_now("read pair did not complete");
            if (accept_o && !b_acc)
            begin
                b_acc = 1'b1;
                @(posedge clk_i);
                #1;
                rd_i = 1'b0;
            end
        end
        @(posedge clk_i);
        #1;
    endtask

    //--------------------------------------------------
    // Directed tests
    //--------------------------------------------------
    task automatic init_sequence();
        logic [3:0]  cmds [$];
        logic [13:0] addrs [$];
        int n;
        @(negedge clk_i);
        // Pin state right after reset
        check("cke_o", 32'h0, cke_o);
        check("command", NOP, {cs_o, ras_o, cas_o, we_o});
        check("data_oe_o", 32'h0, data_oe_o);
        check("ack_o", 32'h0, ack_o);
        n = 0;
        while (cmds.size() < 4)
        begin
            check("accept_o", 32'h0, accept_o);
            if ({cs_o, ras_o, cas_o, we_o} != NOP)
            begin
                cmds.push_back({cs_o, ras_o, cas_o, we_o});
                addrs.push_back(dev_addr);
            end
            n++;
            if (n > `SDRAM_START_DELAY + 300)
                fail_now("init command sequence did not finish");
            @(negedge clk_i);
        end
        check("cke_o", 32'h1, cke_o);
        check("init cmd 0", PRE, cmds[0]);
        check("precharge addr_o[10]", 32'h1, addrs[0][`SDRAM_AP_BIT]);
        check("init cmd 1", REF, cmds[1]);
        check("init cmd 2", REF, cmds[2]);
        check("init cmd 3", LMR, cmds[3]);
        check("mode addr_o", 14'b0000_0_00_010_0_000, addrs[3]);
        @(posedge clk_i);
        #1;
    endtask

    task automatic write_then_read();
        logic [31:0] a, d, r;
        int lat;
        a = rand_addr(2'd0, 14'($urandom));
        d = $urandom;
        access(4'hf, a, d, r, lat);
        check("write ack latency", 32'd1, lat);
        access(4'h0, a, 0, r, lat);
        check("read_data_o", d, r);
        check("read ack latency", `SDRAM_READ_LATENCY + 3, lat);
    endtask

    task automatic partial_write();
        logic [31:0] a, old_w, new_w, r;
        int lat;
        a = rand_addr(2'd3, 14'($urandom));
        old_w = $urandom;
        new_w = $urandom;
        access(4'hf, a, old_w, r, lat);
        access(4'b0101, a, new_w, r, lat);
        check("dqm_o", 32'b1010, last_dqm);
        access(4'h0, a, 0, r, lat);
        check("read_data_o", {old_w[31:24], new_w[23:16], old_w[15:8], new_w[7:0]}, r);
    endtask

    // Waits for a refresh so the next accesses see no refresh
    task automatic wait_refresh();
        int start;
        int n;
        start = refresh_count;
        n = 0;
        while (refresh_count == start)
        begin
            n++;
            if (n > 2 * (`SDRAM_REFRESH_CYCLES + 1))
                fail_now("no refresh seen in two refresh periods");
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic row_miss_same_bank();
        logic [31:0] a, b, da, db, r;
        logic [13:0] row;
        int lat, pre0, act0;
        row = 14'($urandom);
        a = rand_addr(2'd2, row);
        b = rand_addr(2'd2, row ^ 14'h1);
        da = $urandom;
        db = $urandom;
        wait_refresh();
        access(4'hf, a, da, r, lat);
        pre0 = pre_count;
        act0 = act_count;
        access(4'hf, b, db, r, lat);
        check("single precharges", pre0 + 1, pre_count);
        check("precharge bank", 32'd2, last_pre_bank);
        check("activates", act0 + 1, act_count);
        access(4'h0, a, 0, r, lat);
        check("read_data_o row a", da, r);
        access(4'h0, b, 0, r, lat);
        check("read_data_o row b", db, r);
    endtask

    task automatic alternate_banks();
        logic [31:0] a, b, da, db, r, r2;
        int lat, pre0;
        a = rand_addr(2'd1, 14'($urandom));
        b = rand_addr(2'd2, 14'($urandom));
        da = $urandom;
        db = $urandom;
        access(4'hf, a, da, r, lat);
        access(4'hf, b, db, r, lat);
        // Both rows open from here on
        pre0 = pre_count;
        access(4'h0, a, 0, r, lat);
        check("read_data_o bank 1", da, r);
        access(4'h0, b, 0, r, lat);
        check("read_data_o bank 2", db, r);
        read_pair(a, b, r, r2);
        check("read_data_o first of pair", da, r);
        check("read_data_o second of pair", db, r2);
        check("single precharges", pre0, pre_count);
    endtask

    task automatic idle_refresh();
        int start, diff, expect_n;
        start = refresh_count;
        repeat (2000)
            @(posedge clk_i);
        #1;
        diff = refresh_count - start;
        expect_n = 2000 / (`SDRAM_REFRESH_CYCLES + 1);
        // One refresh of slack either side
        if (diff < expect_n - 1 || diff > expect_n + 1)
            check("refresh count", expect_n, diff);
    endtask

    initial
    begin
        void'($urandom(32'h5adae59d));
        rst_i = 1'b1;
        wr_i = '0;
        rd_i = 1'b0;
        addr_i = '0;
        write_data_i = '0;
        repeat (10)
            @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        init_sequence();
        write_then_read();
        partial_write();
        row_miss_same_bank();
        alternate_banks();
        idle_refresh();
        $display("Test passed");
        $finish;
    end

endmodule
